//--- q15_float_stream.f
src/fixed_float_pkg.sv
src/leading_one_encoder.sv
src/sample_capture.sv
src/sample_fifo.sv
src/q15_to_float.sv
src/q15_float_stream.sv
tests/q15_float_stream_checker.sv
tests/q15_float_stream_tb.sv

//--- src/fixed_float_pkg.sv
// widths and constants of the q15 to float stream
// sample, float word and result types
`default_nettype none

package fixed_float_pkg;

  // q15 sample format
  localparam int QWIDTH = 16;
  localparam int RADIX  = 15;

  // ieee-754 single precision
  localparam int MBITS = 23;
  localparam int EBITS = 8;
  localparam int FBITS = 32;
  localparam int BIAS  = 127;

  // bit position within a sample from 0 to 15
  localparam int LZ_WIDTH = 4;

  // sequence tag carried from capture to result
  localparam int SEQ_WIDTH = 4;

  // sample buffer
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // saturating count of dropped strobes
  localparam int DROP_WIDTH = 8;

  typedef struct packed {
    logic signed [QWIDTH-1:0] data;
    logic [SEQ_WIDTH-1:0]     seq;
  } q15_sample_t;

  typedef struct packed {
    logic             sign;
    logic [EBITS-1:0] exponent;
    logic [MBITS-1:0] mantissa;
  } float_fields_t;

  // one float built from its fields or handled as a plain word
  typedef union packed {
    logic [FBITS-1:0] raw;
    float_fields_t    fields;
  } float_word_u;

  typedef struct packed {
    float_word_u          word;
    logic [SEQ_WIDTH-1:0] seq;
  } float_out_t;

endpackage

`default_nettype wire

//--- src/leading_one_encoder.sv
// priority encoder for the most significant set bit
// of a sample magnitude
`timescale 1ns/10ps
`default_nettype none

module leading_one_encoder
  import fixed_float_pkg::*;
(
  input  logic [QWIDTH-1:0]   magnitude,
  output logic [LZ_WIDTH-1:0] position
);

  // scan upwards so the highest set bit wins
  // a zero input leaves position at 0
  always_comb begin
    position = '0;
    for (int i = 0; i < QWIDTH; i++) begin
      if (magnitude[i]) begin
        position = LZ_WIDTH'(i);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/q15_float_stream.sv
// top level of the q15 to float stream
// capture stage, sample fifo and float converter
`timescale 1ns/10ps
`default_nettype none

module q15_float_stream
  import fixed_float_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [QWIDTH-1:0]     sample_in,
  input  logic                  sample_stb,
  input  logic                  hold,
  output float_out_t            result,
  output logic                  result_stb,
  output logic [DROP_WIDTH-1:0] drop_count
);

  q15_sample_t wr_sample;
  q15_sample_t head;
  logic        push;
  logic        pop;
  logic        full;
  logic        empty;

  sample_capture i_capture (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample_in  (sample_in),
    .sample_stb (sample_stb),
    .full       (full),
    .wr_sample  (wr_sample),
    .push       (push),
    .drop_count (drop_count)
  );

  sample_fifo i_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_sample (wr_sample),
    .push      (push),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .empty     (empty)
  );

  q15_to_float i_convert (
    .clk        (clk),
    .arst_n     (arst_n),
    .head       (head),
    .empty      (empty),
    .hold       (hold),
    .pop        (pop),
    .result     (result),
    .result_stb (result_stb)
  );

endmodule

`default_nettype wire

//--- src/q15_to_float.sv
// output stage of the stream
// pops samples and converts q15 to single precision with a result strobe
`timescale 1ns/10ps
`default_nettype none

module q15_to_float
  import fixed_float_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  q15_sample_t head,
  input  logic        empty,
  input  logic        hold,
  output logic        pop,
  output float_out_t  result,
  output logic        result_stb
);

  logic                is_neg;
  logic                is_zero;
  logic [QWIDTH-1:0]   magnitude;
  logic [QWIDTH-1:0]   aligned;
  logic [LZ_WIDTH-1:0] position;
  logic [EBITS-1:0]    exponent;
  logic [MBITS-1:0]    mantissa;
  float_word_u         word_d;

  // take a sample whenever one waits and downstream is not holding
  assign pop = !empty && !hold;

  assign is_neg  = head.data[QWIDTH-1];
  assign is_zero = (head.data == '0);

  // two's complement absolute value where 0x8000 stays 0x8000
  assign magnitude = is_neg ? (~head.data + 1'b1) : head.data;

  leading_one_encoder i_lead_one (
    .magnitude (magnitude),
    .position  (position)
  );

  // move the leading one to the msb and drop it as the hidden bit
  assign aligned  = magnitude << (LZ_WIDTH'(QWIDTH - 1) - position);
  assign mantissa = {aligned[QWIDTH-2:0], {(MBITS - QWIDTH + 1){1'b0}}};

  // unbiased exponent is position minus the fraction bits
  assign exponent = EBITS'(BIAS) + EBITS'(position) - EBITS'(RADIX);

  always_comb begin
    if (is_zero) begin
      word_d.raw = '0;
    end else begin
      word_d.fields.sign     = is_neg;
      word_d.fields.exponent = exponent;
      word_d.fields.mantissa = mantissa;
    end
  end

  // result payload loads only on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      result.word <= word_d;
      result.seq  <= head.seq;
    end
  end

  // one strobe in the cycle after each pop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_stb <= 1'b0;
    end else begin
      result_stb <= pop;
    end
  end

endmodule

`default_nettype wire

//--- src/sample_capture.sv
// input stage of the stream
// registers strobed samples, tags them and counts drops on a full buffer
`timescale 1ns/10ps
`default_nettype none

module sample_capture
  import fixed_float_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic [QWIDTH-1:0] sample_in,
  input  logic              sample_stb,
  input  logic              full,
  output q15_sample_t       wr_sample,
  output logic              push,
  output logic [DROP_WIDTH-1:0] drop_count
);

  logic                 stb_q;
  logic [QWIDTH-1:0]    data_q;
  logic [SEQ_WIDTH-1:0] seq_q;
  logic                 drop;

  // input register where data loads only on a strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= sample_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_stb) begin
      data_q <= sample_in;
    end
  end

  // the full level is checked in the same cycle the write happens
  assign push = stb_q && !full;
  assign drop = stb_q && full;

  assign wr_sample.data = data_q;
  assign wr_sample.seq  = seq_q;

  // tag only advances on accepted samples so results stay gap free
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seq_q <= '0;
    end else if (push) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  // saturating drop counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/sample_fifo.sv
// show-ahead fifo of tagged samples
// circular buffer with occupancy count, full and empty levels
`timescale 1ns/10ps
`default_nettype none

module sample_fifo
  import fixed_float_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  q15_sample_t wr_sample,
  input  logic        push,
  input  logic        pop,
  output q15_sample_t head,
  output logic        full,
  output logic        empty
);

  q15_sample_t        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               wr_en;
  logic               rd_en;

  // ignore requests that would overflow or underflow
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // head shows the oldest entry without a read cycle
  assign head = mem[rd_ptr];

  // sample storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_sample;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // occupancy count that push and pop together leave unchanged
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tests/q15_float_stream_checker.sv
// assertions on the fifo strobes and the result strobe
// bound into the stream top level
`timescale 1ns/10ps
`default_nettype none

module q15_float_stream_checker (
  input logic clk,
  input logic arst_n,
  input logic push,
  input logic pop,
  input logic full,
  input logic empty,
  input logic hold,
  input logic result_stb
);

  // number of failed assertions so far
  int fail_count = 0;

  // capture only writes while there is room
  push_not_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
    else begin
      fail_count++;
      $error("push while the fifo is full");
    end

  // converter only takes a waiting sample with downstream free
  pop_allowed: assert property (@(posedge clk) disable iff (!arst_n) pop |-> (!empty && !hold))
    else begin
      fail_count++;
      $error("pop while the fifo is empty or hold is high");
    end

  // one result strobe exactly one cycle after each pop
  stb_after_pop: assert property (@(posedge clk) disable iff (!arst_n) pop |=> result_stb)
    else begin
      fail_count++;
      $error("no result strobe one cycle after a pop");
    end

  stb_only_after_pop: assert property (@(posedge clk) disable iff (!arst_n) !pop |=> !result_stb)
    else begin
      fail_count++;
      $error("result strobe without a pop in the cycle before");
    end

  levels_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(empty && full))
    else begin
      fail_count++;
      $error("fifo reports empty and full at once");
    end

endmodule

bind q15_float_stream q15_float_stream_checker i_checker (
  .clk        (clk),
  .arst_n     (arst_n),
  .push       (push),
  .pop        (pop),
  .full       (full),
  .empty      (empty),
  .hold       (hold),
  .result_stb (result_stb)
);

`default_nettype wire

//--- tests/q15_float_stream_tb.sv
// testbench for the q15 to float stream
// directed table, random streams, back-pressure and reset against a cycle model
`timescale 1ns/10ps
`default_nettype none

module q15_float_stream_tb
  import fixed_float_pkg::*;
();

  localparam int N_TABLE     = 6;
  localparam int N_RANDOM    = 200;
  localparam int N_MIXED     = 150;
  localparam int HOLD_MARGIN = 300;
  localparam int TIMEOUT     = (N_TABLE + N_RANDOM + N_MIXED) * 4 + HOLD_MARGIN;

  typedef struct packed {
    logic [QWIDTH-1:0] q;
    logic [FBITS-1:0]  f;
  } vector_t;

  typedef struct packed {
    logic [FBITS-1:0]     word;
    logic [SEQ_WIDTH-1:0] seq;
    logic [31:0]          stamp;
  } expect_t;

  logic                  clk;
  logic                  arst_n;
  logic [QWIDTH-1:0]     sample_in;
  logic                  sample_stb;
  logic                  hold;
  float_out_t            result;
  logic                  result_stb;
  logic [DROP_WIDTH-1:0] drop_count;

  // directed samples and their raw floats
  vector_t vectors [N_TABLE] = '{
    '{16'h0000, 32'h0000_0000},
    '{16'h4000, 32'h3F00_0000},
    '{16'h8000, 32'hBF80_0000},
    '{16'h7FFF, 32'h3F7F_FE00},
    '{16'h0001, 32'h3800_0000},
    '{16'hFFFF, 32'hB800_0000}
  };

  int   seed        = 51583;
  int   n_checks    = 0;
  int   n_errors    = 0;
  int   n_results   = 0;
  int   cycle_count = 0;
  int   mon_cycle   = 0;
  logic check_latency;

  // model of capture and fifo occupancy
  expect_t              exp_q [$];
  logic                 stb_m;
  logic [QWIDTH-1:0]    data_m;
  int                   strobe_cycle_m;
  int                   count_m;
  logic [SEQ_WIDTH-1:0] seq_m;
  int                   drops_m;

  q15_float_stream i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample_in  (sample_in),
    .sample_stb (sample_stb),
    .hold       (hold),
    .result     (result),
    .result_stb (result_stb),
    .drop_count (drop_count)
  );

  always #5 clk = ~clk;

  // single precision value of a q15 sample
  function automatic logic [FBITS-1:0] float_of_q15(input logic [QWIDTH-1:0] q);
    int          mag;
    int          pos;
    logic        sign;
    logic [7:0]  exp_field;
    logic [22:0] man;
    if (q == '0) begin
      return '0;
    end
    sign = q[15];
    mag  = sign ? (65536 - int'(q)) : int'(q);
    pos  = 15;
    // normalize until the leading one sits at bit 15
    while (mag < 32768) begin
      mag = mag * 2;
      pos = pos - 1;
    end
    exp_field = 8'(BIAS + pos - RADIX);
    man       = 23'((mag - 32768) * 256);
    return {sign, exp_field, man};
  endfunction

  function automatic logic [QWIDTH-1:0] next_random();
    return QWIDTH'($random(seed));
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic drive_strobe(input logic [QWIDTH-1:0] value);
    @(posedge clk);
    sample_in  <= value;
    sample_stb <= 1'b1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    sample_stb <= 1'b0;
  endtask

  task automatic wait_result(output logic found);
    int n;
    found = 1'b0;
    n     = 0;
    while (!found && n < 20) begin
      @(posedge clk);
      n++;
      if (result_stb === 1'b1) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      report_error("no result strobe arrived for a directed sample");
    end
  endtask

  // sampled on the falling edge after the model has settled
  task automatic wait_drained();
    @(negedge clk);
    while (exp_q.size() != 0 || count_m != 0 || stb_m) begin
      @(negedge clk);
    end
  endtask

  // result checker and cycle model of the stream
  always @(posedge clk) begin
    expect_t entry;
    logic    push_m;
    logic    pop_m;
    mon_cycle++;
    if (!arst_n) begin
      exp_q.delete();
      stb_m   = 1'b0;
      count_m = 0;
      seq_m   = '0;
      drops_m = 0;
    end else begin
      check_value("drop_count", drop_count, drops_m);
      if (result_stb === 1'b1) begin
        n_results++;
        if (exp_q.size() == 0) begin
          report_error("result strobe with no sample outstanding");
        end else begin
          entry = exp_q.pop_front();
          check_value("result.word", result.word.raw, entry.word);
          check_value("result.seq", result.seq, entry.seq);
          if (check_latency) begin
            check_value("result latency", mon_cycle - entry.stamp, 3);
          end
        end
      end
      push_m = stb_m && (count_m < FIFO_DEPTH);
      pop_m  = (count_m > 0) && !hold;
      if (push_m) begin
        entry.word  = float_of_q15(data_m);
        entry.seq   = seq_m;
        entry.stamp = strobe_cycle_m;
        exp_q.push_back(entry);
        seq_m = seq_m + 1'b1;
      end else if (stb_m && drops_m < 255) begin
        drops_m++;
      end
      count_m = count_m + int'(push_m) - int'(pop_m);
      stb_m   = sample_stb;
      if (sample_stb) begin
        data_m         = sample_in;
        strobe_cycle_m = mon_cycle;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("timeout after %0d cycles, the stream did not finish", cycle_count);
      $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    logic              found;
    logic [QWIDTH-1:0] ctrl;
    logic [QWIDTH-1:0] value;
    int                base;
    clk           = 1'b0;
    arst_n        = 1'b0;
    sample_in     = '0;
    sample_stb    = 1'b0;
    hold          = 1'b0;
    check_latency = 1'b1;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    drive_idle();

    // directed table with one sample at a time
    for (int i = 0; i < N_TABLE; i++) begin
      drive_strobe(vectors[i].q);
      drive_idle();
      wait_result(found);
      if (found) begin
        check_value("result.word", result.word.raw, vectors[i].f);
      end
      repeat (2) drive_idle();
    end

    // back-to-back random samples with hold low
    for (int i = 0; i < N_RANDOM; i++) begin
      drive_strobe(next_random());
    end
    drive_idle();
    wait_drained();
    check_latency = 1'b0;

    // twelve strobes into a held stream where the last four are dropped
    @(posedge clk);
    hold <= 1'b1;
    for (int i = 0; i < 12; i++) begin
      drive_strobe(next_random());
    end
    repeat (3) drive_idle();
    @(negedge clk);
    check_value("drop_count", drop_count, 4);
    base = n_results;
    @(posedge clk);
    hold <= 1'b0;
    wait_drained();
    check_value("results after release", n_results - base, FIFO_DEPTH);

    // random stream with hold toggling
    for (int i = 0; i < N_MIXED; i++) begin
      ctrl  = next_random();
      value = next_random();
      @(posedge clk);
      hold       <= ctrl[0];
      sample_stb <= (ctrl[2:1] != 2'b00);
      sample_in  <= value;
    end
    @(posedge clk);
    hold       <= 1'b0;
    sample_stb <= 1'b0;
    wait_drained();
    check_value("drop_count", drop_count, drops_m);

    // reset in the middle of a stream
    for (int i = 0; i < 5; i++) begin
      drive_strobe(next_random());
    end
    @(posedge clk);
    arst_n     <= 1'b0;
    sample_stb <= 1'b0;
    @(negedge clk);
    check_value("result_stb", result_stb, 0);
    check_value("drop_count", drop_count, 0);
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    drive_strobe(16'h2000);
    drive_idle();
    wait_result(found);
    if (found) begin
      check_value("result.seq", result.seq, 0);
      check_value("result.word", result.word.raw, float_of_q15(16'h2000));
    end
    wait_drained();
    repeat (2) drive_idle();

    n_errors = n_errors + i_dut.i_checker.fail_count;
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
